// ==== sources.f ====
+incdir+source
source/axi_chan_pkg.sv
source/axi_map_pkg.sv
source/axi_fwd_demux.sv
source/axi_read_arbiter.sv
source/axi_read_path.sv
source/axi_write_path.sv
source/axi_interconnect.sv
verification/axi_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the interconnect testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module axi_tb -o axi_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/axi_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
	exit 0
fi
exit 1

// ==== verification/axi_tb.sv ====
// Interconnect testbench
`timescale 1ns/1ps
`default_nettype none
`include "axi_defines.svh"

module axi_tb;
	import axi_chan_pkg::*;

	localparam int ROUNDS     = 60;
	localparam int MAX_WAIT   = 16;  // Longest expected stall per beat, in cycles
	localparam int TIMEOUT_NS = ROUNDS * 3 * 4 * MAX_WAIT * 8 + 2000;
	localparam int SAMPLE     = 3;   // Look 1 ns before the rising edge

	logic     ACLK;
	logic     ARESETn;
	// Master side indexed by master number
	logic     ar_valid_m [2];
	logic     ar_ready_m [2];
	addr_m_t  ar_data_m  [2];
	logic     r_valid_m  [2];
	logic     r_ready_m  [2];
	rdat_m_t  r_data_m   [2];
	logic     aw_valid_m1;
	logic     aw_ready_m1;
	logic     w_valid_m1;
	logic     w_ready_m1;
	logic     b_valid_m1;
	logic     b_ready_m1;
	addr_m_t  aw_data_m1;
	wdat_t    w_data_m1;
	bresp_m_t b_data_m1;
	// Slave side indexed by slave number
	logic     ar_valid_s [2];
	logic     ar_ready_s [2];
	addr_s_t  ar_data_s  [2];
	logic     r_valid_s  [2];
	logic     r_ready_s  [2];
	rdat_s_t  r_data_s   [2];
	logic     aw_valid_s [2];
	logic     aw_ready_s [2];
	addr_s_t  aw_data_s  [2];
	logic     w_valid_s  [2];
	logic     w_ready_s  [2];
	wdat_t    w_data_s   [2];
	logic     b_valid_s  [2];
	logic     b_ready_s  [2];
	bresp_s_t b_data_s   [2];

	int         errors;
	int         txns;
	logic [3:0] grant_ids [$];  // Master IDs in slave-side AR order
	wdat_t      exp_w     [$];  // W beats still owed to a slave
	logic       last_grant;     // Model of the round-robin pointer

	axi_interconnect uut (
		.ACLK (ACLK), .ARESETn (ARESETn),
		.ar_valid_m0 (ar_valid_m[0]), .ar_ready_m0 (ar_ready_m[0]), .ar_data_m0 (ar_data_m[0]),
		.r_valid_m0 (r_valid_m[0]), .r_ready_m0 (r_ready_m[0]), .r_data_m0 (r_data_m[0]),
		.ar_valid_m1 (ar_valid_m[1]), .ar_ready_m1 (ar_ready_m[1]), .ar_data_m1 (ar_data_m[1]),
		.r_valid_m1 (r_valid_m[1]), .r_ready_m1 (r_ready_m[1]), .r_data_m1 (r_data_m[1]),
		.aw_valid_m1 (aw_valid_m1), .aw_ready_m1 (aw_ready_m1), .aw_data_m1 (aw_data_m1),
		.w_valid_m1 (w_valid_m1), .w_ready_m1 (w_ready_m1), .w_data_m1 (w_data_m1),
		.b_valid_m1 (b_valid_m1), .b_ready_m1 (b_ready_m1), .b_data_m1 (b_data_m1),
		.ar_valid_s0 (ar_valid_s[0]), .ar_ready_s0 (ar_ready_s[0]), .ar_data_s0 (ar_data_s[0]),
		.r_valid_s0 (r_valid_s[0]), .r_ready_s0 (r_ready_s[0]), .r_data_s0 (r_data_s[0]),
		.aw_valid_s0 (aw_valid_s[0]), .aw_ready_s0 (aw_ready_s[0]), .aw_data_s0 (aw_data_s[0]),
		.w_valid_s0 (w_valid_s[0]), .w_ready_s0 (w_ready_s[0]), .w_data_s0 (w_data_s[0]),
		.b_valid_s0 (b_valid_s[0]), .b_ready_s0 (b_ready_s[0]), .b_data_s0 (b_data_s[0]),
		.ar_valid_s1 (ar_valid_s[1]), .ar_ready_s1 (ar_ready_s[1]), .ar_data_s1 (ar_data_s[1]),
		.r_valid_s1 (r_valid_s[1]), .r_ready_s1 (r_ready_s[1]), .r_data_s1 (r_data_s[1]),
		.aw_valid_s1 (aw_valid_s[1]), .aw_ready_s1 (aw_ready_s[1]), .aw_data_s1 (aw_data_s[1]),
		.w_valid_s1 (w_valid_s[1]), .w_ready_s1 (w_ready_s[1]), .w_data_s1 (w_data_s[1]),
		.b_valid_s1 (b_valid_s[1]), .b_ready_s1 (b_ready_s[1]), .b_data_s1 (b_data_s[1])
	);

	initial begin
		ACLK = 1'b0;
		forever #4 ACLK = ~ACLK;  // 8 ns period
	end

	task automatic flag_mismatch(input string name, input logic [63:0] want,
		input logic [63:0] got);
		errors++;
		$display("[ERROR] %s: expected %0h, got %0h", name, want, got);
	endtask

	task automatic flag_failure(input string what);
		errors++;
		$display("[ERROR] %s", what);
	endtask

	// s1 returns the inverted address plus the beat number
	function automatic logic [31:0] read_beat(input logic [31:0] addr, input int n);
		if (addr[`AXI_REGION_HI:`AXI_REGION_LO] == `AXI_REGION_S1)
			return ~addr + 32'(n);
		return addr + 32'(n);
	endfunction

	// ---------------------------------------------------------------------------
	// Slave models
	// ---------------------------------------------------------------------------
	task automatic serve_reads(input int i);
		addr_s_t req;
		logic    hs;
		@(negedge ACLK);
		forever begin
			ar_ready_s[i] = ($urandom % 3) == 0;
			#SAMPLE;
			if (ar_valid_s[i] && ar_ready_s[i]) begin
				req = ar_data_s[i];
				grant_ids.push_back(req.id[3:0]);
				if (req.addr[31:16] != {15'd0, i[0]})
					flag_mismatch("AR slave select", 64'(i), 64'(req.addr[31:16]));
				if (req.id[7:4] != 4'd0)
					flag_mismatch("AR id widening", 64'(req.id[3:0]), 64'(req.id));
				@(negedge ACLK);
				ar_ready_s[i] = 1'b0;
				for (int b = 0; b <= int'(req.len); b++) begin
					repeat ($urandom % 3) @(negedge ACLK);
					r_valid_s[i] = 1'b1;
					r_data_s[i]  = '{id: req.id, data: read_beat(req.addr, b), resp: 2'b00,
						last: (b == int'(req.len))};
					do begin  // Hold the beat until taken
						#SAMPLE;
						hs = r_ready_s[i];
						@(negedge ACLK);
					end while (!hs);
					r_valid_s[i] = 1'b0;
					r_data_s[i]  = '0;
				end
			end else begin
				@(negedge ACLK);
			end
		end
	endtask

	task automatic take_beat(input int i);
		wdat_t want;
		if (exp_w.size() == 0) begin
			flag_failure("Slave received a W beat that was never sent");
		end else begin
			want = exp_w.pop_front();
			if (w_data_s[i] != want)
				flag_mismatch("W beat", 64'(want), 64'(w_data_s[i]));
		end
	endtask

	task automatic serve_writes(input int i);
		addr_s_t req;
		int      k;
		logic    hs;
		@(negedge ACLK);
		forever begin
			aw_ready_s[i] = ($urandom % 3) == 0;
			w_ready_s[i]  = aw_ready_s[i] & 1'($urandom);  // W may ride with AW
			#SAMPLE;
			if (aw_valid_s[i] && aw_ready_s[i]) begin
				req = aw_data_s[i];
				k   = 0;
				if (req.addr[31:16] != {15'd0, i[0]})
					flag_mismatch("AW slave select", 64'(i), 64'(req.addr[31:16]));
				if (req.id[7:4] != 4'd0)
					flag_mismatch("AW id widening", 64'(req.id[3:0]), 64'(req.id));
				if (w_valid_s[i] && w_ready_s[i]) begin
					take_beat(i);
					k++;
				end
				@(negedge ACLK);
				aw_ready_s[i] = 1'b0;
				while (k <= int'(req.len)) begin
					w_ready_s[i] = 1'($urandom);
					#SAMPLE;
					if (w_valid_s[i] && w_ready_s[i]) begin
						take_beat(i);
						k++;
					end
					@(negedge ACLK);
				end
				w_ready_s[i] = 1'b0;
				repeat ($urandom % 3) @(negedge ACLK);
				b_valid_s[i] = 1'b1;
				b_data_s[i]  = '{id: req.id, resp: 2'b00};
				do begin
					#SAMPLE;
					hs = b_ready_s[i];
					@(negedge ACLK);
				end while (!hs);
				b_valid_s[i] = 1'b0;
				b_data_s[i]  = '0;
			end else begin
				if (w_valid_s[i])
					flag_failure("W beat reached a slave with no write open");
				@(negedge ACLK);
			end
		end
	endtask

	// ---------------------------------------------------------------------------
	// Master models started on a falling edge
	// ---------------------------------------------------------------------------
	task automatic master_read(input int m, input addr_m_t req);
		int   n;
		logic hs;
		ar_valid_m[m] = 1'b1;
		ar_data_m[m]  = req;
		do begin
			#SAMPLE;
			hs = ar_ready_m[m];
			@(negedge ACLK);
		end while (!hs);
		ar_valid_m[m] = 1'b0;
		ar_data_m[m]  = '0;
		n = 0;
		while (n <= int'(req.len)) begin
			r_ready_m[m] = 1'($urandom);  // Random back-pressure
			#SAMPLE;
			if (r_valid_m[m] && r_ready_m[m]) begin
				if (r_data_m[m].data != read_beat(req.addr, n))
					flag_mismatch("R data", 64'(read_beat(req.addr, n)), 64'(r_data_m[m].data));
				if (r_data_m[m].id != req.id)
					flag_mismatch("R id", 64'(req.id), 64'(r_data_m[m].id));
				if (r_data_m[m].resp != 2'b00)
					flag_mismatch("R resp", 64'(0), 64'(r_data_m[m].resp));
				if (r_data_m[m].last != (n == int'(req.len)))
					flag_mismatch("R last", 64'(n == int'(req.len)), 64'(r_data_m[m].last));
				n++;
			end
			@(negedge ACLK);
		end
		r_ready_m[m] = 1'b0;
		txns++;
	endtask

	task automatic master_write(input addr_m_t req);
		wdat_t beats [$];
		wdat_t beat;
		logic  aw_hs;  // AW handshake seen
		logic  w_hs;   // W handshake seen
		logic  hs;
		for (int k = 0; k <= int'(req.len); k++) begin
			beat = '{data: 32'($urandom), strb: 4'($urandom), last: (k == int'(req.len))};
			beats.push_back(beat);
			exp_w.push_back(beat);
		end
		fork
			begin
				aw_valid_m1 = 1'b1;
				aw_data_m1  = req;
				do begin
					#SAMPLE;
					aw_hs = aw_ready_m1;
					@(negedge ACLK);
				end while (!aw_hs);
				aw_valid_m1 = 1'b0;
				aw_data_m1  = '0;
			end
			begin
				foreach (beats[k]) begin
					w_valid_m1 = 1'b1;
					w_data_m1  = beats[k];
					do begin
						#SAMPLE;
						w_hs = w_ready_m1;
						@(negedge ACLK);
					end while (!w_hs);
					w_valid_m1 = 1'b0;
					w_data_m1  = '0;
					repeat ($urandom % 2) @(negedge ACLK);  // Gap between beats
				end
			end
		join
		hs = 1'b0;
		while (!hs) begin
			b_ready_m1 = 1'($urandom);
			#SAMPLE;
			hs = b_valid_m1 && b_ready_m1;
			if (hs && b_data_m1.id != req.id)
				flag_mismatch("B id", 64'(req.id), 64'(b_data_m1.id));
			if (hs && b_data_m1.resp != 2'b00)
				flag_mismatch("B resp", 64'(0), 64'(b_data_m1.resp));
			@(negedge ACLK);
		end
		b_ready_m1 = 1'b0;
		txns++;
	endtask

	// Region bit 16 picks the target slave
	function automatic addr_m_t make_req(input logic id_msb);
		return '{id: {id_msb, 3'($urandom)}, addr: {15'd0, 1'($urandom), 16'($urandom)},
			len: 4'($urandom % 4), size: 3'd2, burst: 2'b01};
	endfunction

	initial begin
		fork
			serve_reads(0);
			serve_reads(1);
			serve_writes(0);
			serve_writes(1);
		join_none
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Run stopped by the watchdog after %0d ns", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	// ---------------------------------------------------------------------------
	// Main sequence
	// ---------------------------------------------------------------------------
	initial begin
		addr_m_t req0;
		addr_m_t req1;
		addr_m_t wreq;
		int      mode;
		int      base;
		int      nreads;
		void'($urandom(38));
		errors     = 0;
		txns       = 0;
		last_grant = 1'b0;  // Pointer resets to m0
		ARESETn    = 1'b0;
		for (int m = 0; m < 2; m++) begin
			ar_valid_m[m] = 1'b0;
			ar_data_m[m]  = '0;
			r_ready_m[m]  = 1'b0;
			ar_ready_s[m] = 1'b0;
			r_valid_s[m]  = 1'b0;
			r_data_s[m]   = '0;
			aw_ready_s[m] = 1'b0;
			w_ready_s[m]  = 1'b0;
			b_valid_s[m]  = 1'b0;
			b_data_s[m]   = '0;
		end
		aw_valid_m1 = 1'b0;
		aw_data_m1  = '0;
		w_valid_m1  = 1'b0;
		w_data_m1   = '0;
		b_ready_m1  = 1'b0;
		repeat (2) @(negedge ACLK);
		ARESETn = 1'b1;
		#SAMPLE;
		// Quiet outputs before any master valid
		if (ar_ready_m[0] || ar_ready_m[1] || r_valid_m[0] || r_valid_m[1] || aw_ready_m1 ||
			w_ready_m1 || b_valid_m1)
			flag_failure("Master-side valid or ready high after reset");
		if (ar_valid_s[0] || ar_valid_s[1] || r_ready_s[0] || r_ready_s[1] || aw_valid_s[0] ||
			aw_valid_s[1] || w_valid_s[0] || w_valid_s[1] || b_ready_s[0] || b_ready_s[1])
			flag_failure("Slave-side valid or ready high after reset");

		for (int r = 0; r < ROUNDS; r++) begin
			@(negedge ACLK);
			mode   = (r == 0) ? 2 : int'($urandom % 4);  // 2 is a tie
			req0   = make_req(1'b0);
			req1   = make_req(1'b1);
			wreq   = make_req(1'b1);
			base   = grant_ids.size();
			nreads = (mode == 2) ? 2 : 1;
			fork
				if (mode != 1) master_read(0, req0);
				if (mode == 1 || mode == 2) master_read(1, req1);
				if (mode == 3) master_write(wreq);
			join
			if (grant_ids.size() != base + nreads) begin
				flag_failure("Slave-side AR count does not match the reads issued");
			end else if (mode == 2) begin
				if (grant_ids[base][3] != !last_grant)
					flag_mismatch("Arbitration order", 64'(!last_grant), 64'(grant_ids[base][3]));
				last_grant = grant_ids[base + 1][3];
			end else begin
				last_grant = (mode == 1);
			end
			if (exp_w.size() != 0)
				flag_failure("W beats never reached the addressed slave");
			exp_w.delete();
		end

		$display("Transactions: %0d, errors: %0d", txns, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/axi_interconnect.sv ====
// AXI interconnect, two masters and two slaves
`timescale 1ns/1ps
`default_nettype none

module axi_interconnect (
	input  logic                   ACLK,
	input  logic                   ARESETn,
	// m0, read only
	input  logic                   ar_valid_m0,
	output logic                   ar_ready_m0,
	input  axi_chan_pkg::addr_m_t  ar_data_m0,
	output logic                   r_valid_m0,
	input  logic                   r_ready_m0,
	output axi_chan_pkg::rdat_m_t  r_data_m0,
	// m1, read and write
	input  logic                   ar_valid_m1,
	output logic                   ar_ready_m1,
	input  axi_chan_pkg::addr_m_t  ar_data_m1,
	output logic                   r_valid_m1,
	input  logic                   r_ready_m1,
	output axi_chan_pkg::rdat_m_t  r_data_m1,
	input  logic                   aw_valid_m1,
	output logic                   aw_ready_m1,
	input  axi_chan_pkg::addr_m_t  aw_data_m1,
	input  logic                   w_valid_m1,
	output logic                   w_ready_m1,
	input  axi_chan_pkg::wdat_t    w_data_m1,
	output logic                   b_valid_m1,
	input  logic                   b_ready_m1,
	output axi_chan_pkg::bresp_m_t b_data_m1,
	// s0
	output logic                   ar_valid_s0,
	input  logic                   ar_ready_s0,
	output axi_chan_pkg::addr_s_t  ar_data_s0,
	input  logic                   r_valid_s0,
	output logic                   r_ready_s0,
	input  axi_chan_pkg::rdat_s_t  r_data_s0,
	output logic                   aw_valid_s0,
	input  logic                   aw_ready_s0,
	output axi_chan_pkg::addr_s_t  aw_data_s0,
	output logic                   w_valid_s0,
	input  logic                   w_ready_s0,
	output axi_chan_pkg::wdat_t    w_data_s0,
	input  logic                   b_valid_s0,
	output logic                   b_ready_s0,
	input  axi_chan_pkg::bresp_s_t b_data_s0,
	// s1
	output logic                   ar_valid_s1,
	input  logic                   ar_ready_s1,
	output axi_chan_pkg::addr_s_t  ar_data_s1,
	input  logic                   r_valid_s1,
	output logic                   r_ready_s1,
	input  axi_chan_pkg::rdat_s_t  r_data_s1,
	output logic                   aw_valid_s1,
	input  logic                   aw_ready_s1,
	output axi_chan_pkg::addr_s_t  aw_data_s1,
	output logic                   w_valid_s1,
	input  logic                   w_ready_s1,
	output axi_chan_pkg::wdat_t    w_data_s1,
	input  logic                   b_valid_s1,
	output logic                   b_ready_s1,
	input  axi_chan_pkg::bresp_s_t b_data_s1
);

	// Port names match the channel names one to one
	axi_read_path u_read (.*);   // AR and R of both masters

	axi_write_path u_write (.*); // AW, W and B of m1

endmodule

`default_nettype wire

// ==== source/axi_write_path.sv ====
// Write routing for m1
`timescale 1ns/1ps
`default_nettype none
`include "axi_defines.svh"

module axi_write_path (
	input  logic                   ACLK,
	input  logic                   ARESETn,
	input  logic                   aw_valid_m1,
	output logic                   aw_ready_m1,
	input  axi_chan_pkg::addr_m_t  aw_data_m1,
	input  logic                   w_valid_m1,
	output logic                   w_ready_m1,
	input  axi_chan_pkg::wdat_t    w_data_m1,
	output logic                   b_valid_m1,
	input  logic                   b_ready_m1,
	output axi_chan_pkg::bresp_m_t b_data_m1,
	output logic                   aw_valid_s0,
	input  logic                   aw_ready_s0,
	output axi_chan_pkg::addr_s_t  aw_data_s0,
	output logic                   w_valid_s0,
	input  logic                   w_ready_s0,
	output axi_chan_pkg::wdat_t    w_data_s0,
	input  logic                   b_valid_s0,
	output logic                   b_ready_s0,
	input  axi_chan_pkg::bresp_s_t b_data_s0,
	output logic                   aw_valid_s1,
	input  logic                   aw_ready_s1,
	output axi_chan_pkg::addr_s_t  aw_data_s1,
	output logic                   w_valid_s1,
	input  logic                   w_ready_s1,
	output axi_chan_pkg::wdat_t    w_data_s1,
	input  logic                   b_valid_s1,
	output logic                   b_ready_s1,
	input  axi_chan_pkg::bresp_s_t b_data_s1
);
	import axi_chan_pkg::*;
	import axi_map_pkg::*;

	logic       busy;      // Write in flight until B accepted
	slave_idx_t wslave_q;  // Latched target
	slave_idx_t aw_sel;
	slave_idx_t w_sel;
	logic       aw_en;
	logic       aw_hs;
	logic       w_en;
	logic       b_hs;
	bresp_s_t   b_s;

	// ---------------------------------------------------------------------------
	// AW, idle only
	// ---------------------------------------------------------------------------
	assign aw_sel = slave_of(aw_data_m1.addr);
	assign aw_en  = ~busy & aw_valid_m1;  // awready low while busy
	assign aw_hs  = aw_valid_m1 & aw_ready_m1;

	axi_fwd_demux #(.payload_t(addr_s_t)) u_aw_demux (
		.in_valid   (aw_valid_m1),
		.in_ready   (aw_ready_m1),
		.in_data    (to_slave_addr(aw_data_m1)),
		.sel        (aw_sel),
		.enable     (aw_en),
		.out0_valid (aw_valid_s0),
		.out1_valid (aw_valid_s1),
		.out0_ready (aw_ready_s0),
		.out1_ready (aw_ready_s1),
		.out0_data  (aw_data_s0),
		.out1_data  (aw_data_s1)
	);

	// W opens with the AW handshake, then follows the latch
	assign w_sel = busy ? wslave_q : aw_sel;
	assign w_en  = busy | aw_hs;

	axi_fwd_demux #(.payload_t(wdat_t)) u_w_demux (
		.in_valid   (w_valid_m1),
		.in_ready   (w_ready_m1),
		.in_data    (w_data_m1),
		.sel        (w_sel),
		.enable     (w_en),
		.out0_valid (w_valid_s0),
		.out1_valid (w_valid_s1),
		.out0_ready (w_ready_s0),
		.out1_ready (w_ready_s1),
		.out0_data  (w_data_s0),
		.out1_data  (w_data_s1)
	);

	// ---------------------------------------------------------------------------
	// B from the latched slave
	// ---------------------------------------------------------------------------
	assign b_s        = wslave_q ? b_data_s1 : b_data_s0;
	assign b_valid_m1 = busy & (wslave_q ? b_valid_s1 : b_valid_s0);
	assign b_data_m1  = busy ? bresp_m_t'{id: b_s.id[`AXI_ID_BITS-1:0], resp: b_s.resp} : '0;
	assign b_ready_s0 = busy & ~wslave_q & b_ready_m1;
	assign b_ready_s1 = busy & wslave_q & b_ready_m1;
	assign b_hs       = b_valid_m1 & b_ready_m1;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			busy     <= 1'b0;
			wslave_q <= 1'b0;
		end else if (!busy) begin
			if (aw_hs) begin
				busy     <= 1'b1;
				wslave_q <= aw_sel;
			end
		end else if (b_hs) begin
			busy <= 1'b0;
		end
	end

	// No unmapped write ever offered
	assert property (@(posedge ACLK) disable iff (!ARESETn)
		aw_valid_m1 |-> in_map(aw_data_m1.addr));

endmodule

`default_nettype wire

// ==== source/axi_read_path.sv ====
// AR and R routing
`timescale 1ns/1ps
`default_nettype none
`include "axi_defines.svh"

module axi_read_path (
	input  logic                  ACLK,
	input  logic                  ARESETn,
	input  logic                  ar_valid_m0,
	output logic                  ar_ready_m0,
	input  axi_chan_pkg::addr_m_t ar_data_m0,
	output logic                  r_valid_m0,
	input  logic                  r_ready_m0,
	output axi_chan_pkg::rdat_m_t r_data_m0,
	input  logic                  ar_valid_m1,
	output logic                  ar_ready_m1,
	input  axi_chan_pkg::addr_m_t ar_data_m1,
	output logic                  r_valid_m1,
	input  logic                  r_ready_m1,
	output axi_chan_pkg::rdat_m_t r_data_m1,
	output logic                  ar_valid_s0,
	input  logic                  ar_ready_s0,
	output axi_chan_pkg::addr_s_t ar_data_s0,
	input  logic                  r_valid_s0,
	output logic                  r_ready_s0,
	input  axi_chan_pkg::rdat_s_t r_data_s0,
	output logic                  ar_valid_s1,
	input  logic                  ar_ready_s1,
	output axi_chan_pkg::addr_s_t ar_data_s1,
	input  logic                  r_valid_s1,
	output logic                  r_ready_s1,
	input  axi_chan_pkg::rdat_s_t r_data_s1
);
	import axi_chan_pkg::*;
	import axi_map_pkg::*;

	master_idx_t grant;
	slave_idx_t  target;
	logic        route_en;
	logic        r_done;   // Last R beat handshake
	logic        ar_valid;
	logic        ar_ready;
	addr_s_t     ar_s;
	rdat_s_t     r_s;      // Selected slave's beat
	rdat_m_t     r_m;
	logic        r_valid;
	logic        r_ready;

	axi_read_arbiter u_arb (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.ar_valid_m0 (ar_valid_m0),
		.ar_valid_m1 (ar_valid_m1),
		.ar_addr_m0  (ar_data_m0.addr),
		.ar_addr_m1  (ar_data_m1.addr),
		.r_done      (r_done),
		.grant       (grant),
		.target      (target),
		.route_en    (route_en)
	);

	// ---------------------------------------------------------------------------
	// AR of the granted master
	// ---------------------------------------------------------------------------
	assign ar_valid    = grant ? ar_valid_m1 : ar_valid_m0;
	assign ar_s        = to_slave_addr(grant ? ar_data_m1 : ar_data_m0);
	assign ar_ready_m0 = ar_ready & ~grant;  // Loser sees no ready
	assign ar_ready_m1 = ar_ready & grant;

	axi_fwd_demux #(.payload_t(addr_s_t)) u_ar_demux (
		.in_valid   (ar_valid),
		.in_ready   (ar_ready),
		.in_data    (ar_s),
		.sel        (target),
		.enable     (route_en),
		.out0_valid (ar_valid_s0),
		.out1_valid (ar_valid_s1),
		.out0_ready (ar_ready_s0),
		.out1_ready (ar_ready_s1),
		.out0_data  (ar_data_s0),
		.out1_data  (ar_data_s1)
	);

	// ---------------------------------------------------------------------------
	// R back to the granted master
	// ---------------------------------------------------------------------------
	assign r_s     = target ? r_data_s1 : r_data_s0;
	assign r_valid = route_en & (target ? r_valid_s1 : r_valid_s0);
	assign r_ready = grant ? r_ready_m1 : r_ready_m0;

	// Upper ID bits dropped
	assign r_m = '{id: r_s.id[`AXI_ID_BITS-1:0], data: r_s.data, resp: r_s.resp,
		last: r_s.last};

	assign r_valid_m0 = r_valid & ~grant;
	assign r_valid_m1 = r_valid & grant;
	assign r_data_m0  = (route_en & ~grant) ? r_m : '0;
	assign r_data_m1  = (route_en & grant) ? r_m : '0;
	assign r_ready_s0 = route_en & ~target & r_ready;
	assign r_ready_s1 = route_en & target & r_ready;

	assign r_done = r_valid & r_ready & r_s.last;  // Ends the burst

endmodule

`default_nettype wire

// ==== source/axi_read_arbiter.sv ====
// Read arbiter
`timescale 1ns/1ps
`default_nettype none
`include "axi_defines.svh"

module axi_read_arbiter (
	input  logic                      ACLK,
	input  logic                      ARESETn,
	input  logic                      ar_valid_m0,
	input  logic                      ar_valid_m1,
	input  logic [`AXI_ADDR_BITS-1:0] ar_addr_m0,
	input  logic [`AXI_ADDR_BITS-1:0] ar_addr_m1,
	input  logic                      r_done,
	output axi_map_pkg::master_idx_t  grant,
	output axi_map_pkg::slave_idx_t   target,
	output logic                      route_en
);
	import axi_map_pkg::*;

	logic        busy;        // Read in flight
	master_idx_t last_grant;  // Round-robin pointer
	master_idx_t grant_q;     // Latched master
	slave_idx_t  target_q;    // Latched slave
	master_idx_t pick;        // Winner of the idle cycle
	logic        req_any;

	assign req_any = ar_valid_m0 | ar_valid_m1;

	// ---------------------------------------------------------------------------
	// Round-robin pick
	// ---------------------------------------------------------------------------
	always_comb begin
		case ({ar_valid_m1, ar_valid_m0})
			2'b11:   pick = ~last_grant;  // Both ask so the other master wins
			2'b10:   pick = 1'b1;
			default: pick = 1'b0;
		endcase
	end

	// Live grant in idle so AR can complete at once
	assign grant    = busy ? grant_q : pick;
	assign target   = busy ? target_q : slave_of(pick ? ar_addr_m1 : ar_addr_m0);
	assign route_en = busy | req_any;

	// ---------------------------------------------------------------------------
	// Idle / busy
	// ---------------------------------------------------------------------------
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			busy       <= 1'b0;
			last_grant <= 1'b0;  // m0 first so m1 wins the first tie
			grant_q    <= 1'b0;
			target_q   <= 1'b0;
		end else if (!busy) begin
			if (req_any) begin
				busy       <= 1'b1;
				grant_q    <= pick;
				target_q   <= target;
				last_grant <= pick;
			end
		end else if (r_done) begin
			busy <= 1'b0;  // Last R beat accepted
		end
	end

	// Masters issue mapped reads only
	assert property (@(posedge ACLK) disable iff (!ARESETn)
		!busy && req_any |-> in_map(pick ? ar_addr_m1 : ar_addr_m0));

endmodule

`default_nettype wire

// ==== source/axi_fwd_demux.sv ====
// Valid/ready channel demux
`timescale 1ns/1ps
`default_nettype none

module axi_fwd_demux #(
	parameter type payload_t = logic
) (
	input  logic                    in_valid,
	output logic                    in_ready,
	input  payload_t                in_data,
	input  axi_map_pkg::slave_idx_t sel,
	input  logic                    enable,
	output logic                    out0_valid,
	output logic                    out1_valid,
	input  logic                    out0_ready,
	input  logic                    out1_ready,
	output payload_t                out0_data,
	output payload_t                out1_data
);

	always_comb begin
		// Quiet outputs by default
		out0_valid = 1'b0;
		out1_valid = 1'b0;
		out0_data  = '0;
		out1_data  = '0;
		in_ready   = 1'b0;
		if (enable) begin
			if (sel) begin
				out1_valid = in_valid;
				out1_data  = in_data;
				in_ready   = out1_ready;  // Ready straight from s1
			end else begin
				out0_valid = in_valid;
				out0_data  = in_data;
				in_ready   = out0_ready;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/axi_map_pkg.sv ====
// Interconnect address map
`default_nettype none
`include "axi_defines.svh"

package axi_map_pkg;

	typedef logic slave_idx_t;   // 0 is s0, 1 is s1
	typedef logic master_idx_t;  // 0 is m0, 1 is m1

	// Target slave from the region field
	function automatic slave_idx_t slave_of(input logic [`AXI_ADDR_BITS-1:0] addr);
		return slave_idx_t'(addr[`AXI_REGION_HI:`AXI_REGION_LO] == `AXI_REGION_S1);
	endfunction

	// True for the two mapped regions only
	function automatic logic in_map(input logic [`AXI_ADDR_BITS-1:0] addr);
		logic [`AXI_REGION_HI-`AXI_REGION_LO:0] region;
		region = addr[`AXI_REGION_HI:`AXI_REGION_LO];
		return (region == `AXI_REGION_S0) || (region == `AXI_REGION_S1);
	endfunction

endpackage

`default_nettype wire

// ==== source/axi_chan_pkg.sv ====
// AXI channel payloads
`default_nettype none
`include "axi_defines.svh"

package axi_chan_pkg;

	// AR / AW payload as issued by a master
	typedef struct packed {
		logic [`AXI_ID_BITS-1:0]   id;
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [`AXI_LEN_BITS-1:0]  len;   // Beats minus one
		logic [`AXI_SIZE_BITS-1:0] size;
		logic [1:0]                burst;
	} addr_m_t;

	// Same request toward a slave, wider ID
	typedef struct packed {
		logic [`AXI_IDS_BITS-1:0]  id;
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [`AXI_LEN_BITS-1:0]  len;
		logic [`AXI_SIZE_BITS-1:0] size;
		logic [1:0]                burst;
	} addr_s_t;

	// W beat, identical on both sides
	typedef struct packed {
		logic [`AXI_DATA_BITS-1:0] data;
		logic [`AXI_STRB_BITS-1:0] strb;
		logic                      last;
	} wdat_t;

	typedef struct packed {
		logic [`AXI_ID_BITS-1:0]   id;
		logic [`AXI_DATA_BITS-1:0] data;
		logic [1:0]                resp;
		logic                      last;  // Final beat of the burst
	} rdat_m_t;

	typedef struct packed {
		logic [`AXI_IDS_BITS-1:0]  id;
		logic [`AXI_DATA_BITS-1:0] data;
		logic [1:0]                resp;
		logic                      last;
	} rdat_s_t;

	typedef struct packed {
		logic [`AXI_ID_BITS-1:0] id;
		logic [1:0]              resp;
	} bresp_m_t;

	typedef struct packed {
		logic [`AXI_IDS_BITS-1:0] id;
		logic [1:0]               resp;
	} bresp_s_t;

	// Master request to slave request, ID zero-extended
	function automatic addr_s_t to_slave_addr(input addr_m_t a);
		return '{id: `AXI_IDS_BITS'(a.id), addr: a.addr, len: a.len, size: a.size,
			burst: a.burst};
	endfunction

endpackage

`default_nettype wire

// ==== source/axi_defines.svh ====
// AXI widths and address map
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// ---------------------------------------------------------------------------
// Channel field widths
// ---------------------------------------------------------------------------
// Master side ID, widened to the slave side ID on the way out
`define AXI_ID_BITS   4
`define AXI_IDS_BITS  8
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_LEN_BITS  4
`define AXI_SIZE_BITS 3

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------
// Region field sits in the upper half of the address
`define AXI_REGION_HI 31
`define AXI_REGION_LO 16
// Only two mapped regions
`define AXI_REGION_S0 16'h0000
`define AXI_REGION_S1 16'h0001

`endif
